// File: hw/bus_defs.svh
// Widths, bank size and timeout limit for the shared-bus system.
// Included by every RTL file and by the testbench.
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// word address width
`define BUS_ADDR_W 30

// data width of the bus and of the bank
`define BUS_DATA_W 32

// words in the target bank, addresses below this are valid
`define BUS_BANK_WORDS 16

// consecutive wait cycles that abort a transfer
`define BUS_TOUT_CYCLES 16

`endif

// File: hw/bus_pkg.sv
// Types shared by the masters, the arbiter and the target.
// Import with a wildcard import in the module header.
package bus_pkg;

   // acknowledge from the target, encodings as on the legacy bus
   typedef enum logic [2:0]
   {
      ack_idle = 3'b000,
      ack_wait = 3'b001,
      ack_err  = 3'b011,
      ack_rdy  = 3'b100
   } ack_t;

   // bus master sequencing
   typedef enum logic [2:0]
   {
      mst_idle = 3'b000,  // waiting for a command
      mst_req  = 3'b001,  // bus requested
      mst_addr = 3'b010,  // first cycle as owner
      mst_data = 3'b100   // waiting out the target
   } mst_state_t;

endpackage

// File: hw/bus_master.sv
// Bus master: accepts one command, runs it as one bus transfer and returns
// one response pulse with read data or an error flag.
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_master
   import bus_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  logic                   cmd_read,
   input  logic [`BUS_ADDR_W-1:0] cmd_addr,
   input  logic [`BUS_DATA_W-1:0] cmd_wdata,
   output logic                   rsp_valid,
   output logic [`BUS_DATA_W-1:0] rsp_rdata,
   output logic                   rsp_err,
   output logic                   req,
   input  logic                   gnt,
   output logic [`BUS_ADDR_W-1:0] bus_addr,
   output logic                   bus_read,
   output logic [`BUS_DATA_W-1:0] bus_wdata,
   input  ack_t                   ack,
   input  logic [`BUS_DATA_W-1:0] rdata,
   input  logic                   tout
);

   mst_state_t             state_q;
   logic                   read_q;   // latched command
   logic [`BUS_ADDR_W-1:0] addr_q;
   logic [`BUS_DATA_W-1:0] wdata_q;
   logic                   owner;    // address or data phase
   logic                   done;

   assign owner     = (state_q == mst_addr) || (state_q == mst_data);
   assign done      = owner && ((ack == ack_rdy) || (ack == ack_err) || tout);
   assign cmd_ready = (state_q == mst_idle);
   assign req       = (state_q == mst_req);

   // drive the shared lines only while owning the bus so the arbiter sees zero
   assign bus_addr  = owner ? addr_q : '0;
   assign bus_read  = owner ? read_q : 1'b0;
   assign bus_wdata = owner ? wdata_q : '0;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_q   <= mst_idle;
         rsp_valid <= 1'b0;
      end
      else
      begin
         rsp_valid <= done;  // one cycle after the end
         unique case (state_q)
            mst_idle:
            begin
               if (cmd_valid)
               begin
                  state_q <= mst_req;
               end
            end
            mst_req:
            begin
               if (gnt)
               begin
                  state_q <= mst_addr;
               end
            end
            mst_addr:
            begin
               // target may answer in the very first cycle
               state_q <= done ? mst_idle : mst_data;
            end
            mst_data:
            begin
               if (done)
               begin
                  state_q <= mst_idle;
               end
            end
            default:
            begin
               state_q <= mst_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmd_valid && cmd_ready)
      begin
         read_q  <= cmd_read;
         addr_q  <= cmd_addr;
         wdata_q <= cmd_wdata;
      end
      if (done)
      begin
         rsp_err   <= (ack == ack_err) || tout;
         rsp_rdata <= ((ack == ack_rdy) && read_q) ? rdata : '0;
      end
   end

   // the request must be withdrawn once granted
   a_req_drop: assert property (@(posedge clk) disable iff (!arst_n)
      gnt |=> !req)
      else $error("req still high after gnt");

endmodule

// File: hw/bus_arbiter.sv
// Round-robin arbiter for two masters. Routes the owner's address phase to
// the target, drives sel and aborts a transfer that waits too long.
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_arbiter
   import bus_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   req_0,
   input  logic                   req_1,
   output logic                   gnt_0,
   output logic                   gnt_1,
   input  logic [`BUS_ADDR_W-1:0] addr_0,
   input  logic [`BUS_ADDR_W-1:0] addr_1,
   input  logic                   read_0,
   input  logic                   read_1,
   input  logic [`BUS_DATA_W-1:0] wdata_0,
   input  logic [`BUS_DATA_W-1:0] wdata_1,
   output logic [`BUS_ADDR_W-1:0] bus_addr,
   output logic                   bus_read,
   output logic [`BUS_DATA_W-1:0] bus_wdata,
   output logic                   sel,
   input  ack_t                   ack,
   output logic                   tout
);

   localparam int CNT_W = $clog2(`BUS_TOUT_CYCLES + 1);

   logic             busy_q;   // set from grant until the transfer ends
   logic             owner_q;  // current owner, doubles as last granted
   logic [CNT_W-1:0] cnt_q;    // wait cycles seen so far
   logic             winner;
   logic             xfer_end;

   // the master not granted last wins a tie
   assign winner = (req_0 && req_1) ? !owner_q : req_1;

   // abort on the last allowed wait cycle
   assign tout = sel && (ack == ack_wait) && (cnt_q == CNT_W'(`BUS_TOUT_CYCLES - 1));

   assign xfer_end = sel && ((ack == ack_rdy) || (ack == ack_err) || tout);

   assign bus_addr  = owner_q ? addr_1 : addr_0;
   assign bus_read  = owner_q ? read_1 : read_0;
   assign bus_wdata = owner_q ? wdata_1 : wdata_0;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         gnt_0   <= 1'b0;
         gnt_1   <= 1'b0;
         sel     <= 1'b0;
         busy_q  <= 1'b0;
         owner_q <= 1'b1;  // master 0 wins the first tie
         cnt_q   <= '0;
      end
      else
      begin
         gnt_0 <= 1'b0;  // grant is a single pulse
         gnt_1 <= 1'b0;
         if (!busy_q && (req_0 || req_1))
         begin
            gnt_0   <= !winner;
            gnt_1   <= winner;
            owner_q <= winner;
            busy_q  <= 1'b1;
         end
         if (gnt_0 || gnt_1)
         begin
            sel <= 1'b1;  // owner's address phase starts
         end
         else if (xfer_end)
         begin
            sel    <= 1'b0;
            busy_q <= 1'b0;
         end
         if (sel && (ack == ack_wait) && !tout)
         begin
            cnt_q <= cnt_q + 1'b1;
         end
         else
         begin
            cnt_q <= '0;
         end
      end
   end

   // a selected transfer never outlives the timeout
   a_sel_bounded: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(sel) |-> ##[1:`BUS_TOUT_CYCLES] !sel)
      else $error("sel held past the timeout");

   a_gnt_bus_free: assert property (@(posedge clk) disable iff (!arst_n)
      (gnt_0 || gnt_1) |-> !sel)
      else $error("grant while the bus is selected");

endmodule

// File: hw/bus_target.sv
// Register-bank target. Answers ready with a bank read or write, wait while
// busy is high and error for an address beyond the bank.
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_target
   import bus_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   sel,
   input  logic [`BUS_ADDR_W-1:0] bus_addr,
   input  logic                   bus_read,
   input  logic [`BUS_DATA_W-1:0] bus_wdata,
   input  logic                   busy,
   output ack_t                   ack,
   output logic [`BUS_DATA_W-1:0] rdata
);

   localparam int IDX_W = $clog2(`BUS_BANK_WORDS);

   logic [`BUS_DATA_W-1:0] bank [`BUS_BANK_WORDS];
   logic                   in_range;
   logic [IDX_W-1:0]       idx;
   logic                   wr_en;

   assign in_range = (bus_addr < `BUS_ADDR_W'(`BUS_BANK_WORDS));
   assign idx      = bus_addr[IDX_W-1:0];

   // answer straight from sel so a free target replies in the first cycle
   always_comb
   begin
      if (!sel)
      begin
         ack = ack_idle;
      end
      else if (!in_range)
      begin
         ack = ack_err;
      end
      else if (busy)
      begin
         ack = ack_wait;
      end
      else
      begin
         ack = ack_rdy;
      end
   end

   assign rdata = ((ack == ack_rdy) && bus_read) ? bank[idx] : '0;
   assign wr_en = (ack == ack_rdy) && !bus_read;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < `BUS_BANK_WORDS; i++)
         begin
            bank[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         bank[idx] <= bus_wdata;  // write lands on the ready edge
      end
   end

   // the owner keeps its address phase steady through wait states
   a_addr_held: assert property (@(posedge clk) disable iff (!arst_n)
      (ack == ack_wait) |=>
         (!sel || ($stable(bus_addr) && $stable(bus_read) && $stable(bus_wdata))))
      else $error("address phase changed during a wait");

endmodule

// File: hw/bus_system.sv
// Top level: two bus masters sharing one register-bank target through
// the round-robin arbiter. busy stalls the target.
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_system
   import bus_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   busy,
   input  logic                   cmd_valid_0,
   output logic                   cmd_ready_0,
   input  logic                   cmd_read_0,
   input  logic [`BUS_ADDR_W-1:0] cmd_addr_0,
   input  logic [`BUS_DATA_W-1:0] cmd_wdata_0,
   output logic                   rsp_valid_0,
   output logic [`BUS_DATA_W-1:0] rsp_rdata_0,
   output logic                   rsp_err_0,
   input  logic                   cmd_valid_1,
   output logic                   cmd_ready_1,
   input  logic                   cmd_read_1,
   input  logic [`BUS_ADDR_W-1:0] cmd_addr_1,
   input  logic [`BUS_DATA_W-1:0] cmd_wdata_1,
   output logic                   rsp_valid_1,
   output logic [`BUS_DATA_W-1:0] rsp_rdata_1,
   output logic                   rsp_err_1
);

   logic                   req_0, req_1;
   logic                   gnt_0, gnt_1;
   logic [`BUS_ADDR_W-1:0] addr_0, addr_1;
   logic                   read_0, read_1;
   logic [`BUS_DATA_W-1:0] wdata_0, wdata_1;
   logic [`BUS_ADDR_W-1:0] bus_addr;  // owner's lines after the mux
   logic                   bus_read;
   logic [`BUS_DATA_W-1:0] bus_wdata;
   logic                   sel;
   logic                   tout;
   ack_t                   ack;
   logic [`BUS_DATA_W-1:0] rdata;

   bus_master u_master_0 (
      .clk(clk), .arst_n(arst_n),
      .cmd_valid(cmd_valid_0), .cmd_ready(cmd_ready_0), .cmd_read(cmd_read_0),
      .cmd_addr(cmd_addr_0), .cmd_wdata(cmd_wdata_0),
      .rsp_valid(rsp_valid_0), .rsp_rdata(rsp_rdata_0), .rsp_err(rsp_err_0),
      .req(req_0), .gnt(gnt_0),
      .bus_addr(addr_0), .bus_read(read_0), .bus_wdata(wdata_0),
      .ack(ack), .rdata(rdata), .tout(tout)
   );

   bus_master u_master_1 (
      .clk(clk), .arst_n(arst_n),
      .cmd_valid(cmd_valid_1), .cmd_ready(cmd_ready_1), .cmd_read(cmd_read_1),
      .cmd_addr(cmd_addr_1), .cmd_wdata(cmd_wdata_1),
      .rsp_valid(rsp_valid_1), .rsp_rdata(rsp_rdata_1), .rsp_err(rsp_err_1),
      .req(req_1), .gnt(gnt_1),
      .bus_addr(addr_1), .bus_read(read_1), .bus_wdata(wdata_1),
      .ack(ack), .rdata(rdata), .tout(tout)
   );

   bus_arbiter u_arbiter (
      .clk(clk), .arst_n(arst_n),
      .req_0(req_0), .req_1(req_1), .gnt_0(gnt_0), .gnt_1(gnt_1),
      .addr_0(addr_0), .addr_1(addr_1), .read_0(read_0), .read_1(read_1),
      .wdata_0(wdata_0), .wdata_1(wdata_1),
      .bus_addr(bus_addr), .bus_read(bus_read), .bus_wdata(bus_wdata),
      .sel(sel), .ack(ack), .tout(tout)
   );

   bus_target u_target (
      .clk(clk), .arst_n(arst_n),
      .sel(sel), .bus_addr(bus_addr), .bus_read(bus_read), .bus_wdata(bus_wdata),
      .busy(busy), .ack(ack), .rdata(rdata)
   );

endmodule

// File: test/bus_tb.sv
// Testbench for the shared-bus system: drives both command ports, keeps a
// shadow of the bank and lets assertions judge every response
`timescale 1ns/1ps
`include "bus_defs.svh"

// follows the commands of one master and checks each of its responses
module rsp_checker #(
   parameter int ID = 0
)
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   cmd_valid,
   input  logic                   cmd_ready,
   input  logic                   rsp_valid,
   input  logic                   rsp_err,
   input  logic [`BUS_DATA_W-1:0] rsp_rdata,
   input  logic                   want_read,
   input  logic                   want_err,
   input  logic [`BUS_DATA_W-1:0] want_rdata,
   output logic                   pending,
   output int                     accepts,
   output int                     responses,
   output int                     fails
);

   logic                   exp_read;  // taken over at acceptance
   logic                   exp_err;
   logic [`BUS_DATA_W-1:0] exp_rdata;
   int                     fail_cnt = 0;

   assign fails = fail_cnt;

   task automatic report(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      fail_cnt++;
   endtask

   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pending   <= 1'b0;
         accepts   <= 0;
         responses <= 0;
         exp_read  <= 1'b0;
         exp_err   <= 1'b0;
         exp_rdata <= '0;
      end
      else
      begin
         if (cmd_valid && cmd_ready)
         begin
            pending   <= 1'b1;  // also covers a response in the same cycle
            accepts   <= accepts + 1;
            exp_read  <= want_read;
            exp_err   <= want_err;
            exp_rdata <= want_rdata;
         end
         else if (rsp_valid)
         begin
            pending <= 1'b0;
         end
         if (rsp_valid)
         begin
            responses <= responses + 1;
         end
      end
   end

   a_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> cmd_ready)
      else report($sformatf("master %0d not ready after reset", ID));

   a_no_stray_rsp: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |-> pending)
      else report($sformatf("master %0d responded without an accepted command", ID));

   a_ready_low: assert property (@(posedge clk) disable iff (!arst_n)
      (pending && !rsp_valid) |-> !cmd_ready)
      else report($sformatf("master %0d ready while a command is outstanding", ID));

   a_err_flag: assert property (@(posedge clk) disable iff (!arst_n)
      rsp_valid |-> (rsp_err == exp_err))
      else report($sformatf("master %0d rsp_err %0b, expected %0b",
                            ID, $sampled(rsp_err), $sampled(exp_err)));

   a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
      (rsp_valid && exp_read && !exp_err) |-> (rsp_rdata == exp_rdata))
      else report($sformatf("master %0d read data %h, expected %h",
                            ID, $sampled(rsp_rdata), $sampled(exp_rdata)));

endmodule

module bus_tb;

   localparam int IDX_W       = $clog2(`BUS_BANK_WORDS);
   localparam int MAX_CMDS    = 40;                          // bound over all tests
   localparam int CMD_CYCLES  = 2 * `BUS_TOUT_CYCLES + 16;   // worst command incl. a stall
   localparam int WATCHDOG_NS = (MAX_CMDS * CMD_CYCLES + 100) * 20;

   logic                   clk;
   logic                   arst_n;
   logic                   busy;
   logic                   cmd_valid_0, cmd_valid_1;
   logic                   cmd_ready_0, cmd_ready_1;
   logic                   cmd_read_0, cmd_read_1;
   logic [`BUS_ADDR_W-1:0] cmd_addr_0, cmd_addr_1;
   logic [`BUS_DATA_W-1:0] cmd_wdata_0, cmd_wdata_1;
   logic                   rsp_valid_0, rsp_valid_1;
   logic [`BUS_DATA_W-1:0] rsp_rdata_0, rsp_rdata_1;
   logic                   rsp_err_0, rsp_err_1;
   logic                   want_read_0, want_read_1;  // expectation of the offered command
   logic                   want_err_0, want_err_1;
   logic [`BUS_DATA_W-1:0] want_rdata_0, want_rdata_1;
   logic                   pending_0, pending_1;
   int                     accepts_0, accepts_1;
   int                     responses_0, responses_1;
   int                     fails_0, fails_1;
   logic                   owe_0, owe_1;  // this master must answer next
   logic                   last_done;     // master that completed last, so granted last
   logic                   last_known;    // some transfer completed since reset
   logic                   tie_open;      // both accepted together, first answer pending
   logic                   tie_winner;    // master that must answer first
   logic [`BUS_DATA_W-1:0] shadow [`BUS_BANK_WORDS];
   int                     top_fails = 0;
   int                     end_fails = 0;
   int                     seen_fails = 0;
   int                     tests = 0;
   int                     cmds = 0;

   initial clk = 1'b0;
   always #10 clk = ~clk;

   bus_system dut (
      .clk(clk), .arst_n(arst_n), .busy(busy),
      .cmd_valid_0(cmd_valid_0), .cmd_ready_0(cmd_ready_0), .cmd_read_0(cmd_read_0),
      .cmd_addr_0(cmd_addr_0), .cmd_wdata_0(cmd_wdata_0),
      .rsp_valid_0(rsp_valid_0), .rsp_rdata_0(rsp_rdata_0), .rsp_err_0(rsp_err_0),
      .cmd_valid_1(cmd_valid_1), .cmd_ready_1(cmd_ready_1), .cmd_read_1(cmd_read_1),
      .cmd_addr_1(cmd_addr_1), .cmd_wdata_1(cmd_wdata_1),
      .rsp_valid_1(rsp_valid_1), .rsp_rdata_1(rsp_rdata_1), .rsp_err_1(rsp_err_1)
   );

   rsp_checker #(.ID(0)) chk_0 (
      .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid_0), .cmd_ready(cmd_ready_0),
      .rsp_valid(rsp_valid_0), .rsp_err(rsp_err_0), .rsp_rdata(rsp_rdata_0),
      .want_read(want_read_0), .want_err(want_err_0), .want_rdata(want_rdata_0),
      .pending(pending_0), .accepts(accepts_0), .responses(responses_0), .fails(fails_0)
   );

   rsp_checker #(.ID(1)) chk_1 (
      .clk(clk), .arst_n(arst_n), .cmd_valid(cmd_valid_1), .cmd_ready(cmd_ready_1),
      .rsp_valid(rsp_valid_1), .rsp_err(rsp_err_1), .rsp_rdata(rsp_rdata_1),
      .want_read(want_read_1), .want_err(want_err_1), .want_rdata(want_rdata_1),
      .pending(pending_1), .accepts(accepts_1), .responses(responses_1), .fails(fails_1)
   );

   // a response while the other master waits makes that master next
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         owe_0 <= 1'b0;
         owe_1 <= 1'b0;
      end
      else
      begin
         owe_0 <= rsp_valid_0 ? 1'b0 : (owe_0 || (rsp_valid_1 && pending_0));
         owe_1 <= rsp_valid_1 ? 1'b0 : (owe_1 || (rsp_valid_0 && pending_1));
      end
   end

   // two commands accepted in one cycle meet at the arbiter as a tie
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         last_done  <= 1'b0;
         last_known <= 1'b0;
         tie_open   <= 1'b0;
         tie_winner <= 1'b0;
      end
      else
      begin
         if (rsp_valid_0 || rsp_valid_1)
         begin
            last_done  <= rsp_valid_1;
            last_known <= 1'b1;
         end
         if (cmd_valid_0 && cmd_ready_0 && cmd_valid_1 && cmd_ready_1)
         begin
            tie_open   <= last_known || rsp_valid_0 || rsp_valid_1;
            tie_winner <= (rsp_valid_0 || rsp_valid_1) ? !rsp_valid_1 : !last_done;
         end
         else if (rsp_valid_0 || rsp_valid_1)
         begin
            tie_open <= 1'b0;
         end
      end
   end

   task automatic flag_error(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      top_fails++;
   endtask

   a_turn_0: assert property (@(posedge clk) disable iff (!arst_n) rsp_valid_0 |-> !owe_1)
      else flag_error("master 0 answered twice while master 1 waited");

   a_turn_1: assert property (@(posedge clk) disable iff (!arst_n) rsp_valid_1 |-> !owe_0)
      else flag_error("master 1 answered twice while master 0 waited");

   a_tie_order: assert property (@(posedge clk) disable iff (!arst_n)
      (tie_open && (rsp_valid_0 || rsp_valid_1)) |-> (rsp_valid_1 == tie_winner))
      else flag_error("tie not won by the master granted less recently");

   function automatic int total_fails();
      return fails_0 + fails_1 + top_fails + end_fails;
   endfunction

   function automatic logic in_bank(input logic [`BUS_ADDR_W-1:0] addr);
      return addr < `BUS_ADDR_W'(`BUS_BANK_WORDS);
   endfunction

   function automatic logic ready_of(input int m);
      return (m == 0) ? cmd_ready_0 : cmd_ready_1;
   endfunction

   function automatic logic pending_of(input int m);
      return (m == 0) ? pending_0 : pending_1;
   endfunction

   function automatic logic [`BUS_ADDR_W-1:0] rand_addr();
      return `BUS_ADDR_W'($urandom_range(`BUS_BANK_WORDS - 1, 0));
   endfunction

   // offers one command to master m and returns once it is accepted
   task automatic send_cmd(input int m, input logic rd, input logic [`BUS_ADDR_W-1:0] addr,
                           input logic [`BUS_DATA_W-1:0] wdata, input logic stall);
      logic                   err_exp;
      logic [`BUS_DATA_W-1:0] rdata_exp;
      err_exp   = !in_bank(addr) || stall;  // out of range or busy past the limit
      rdata_exp = '0;
      if (!err_exp && rd)
      begin
         rdata_exp = shadow[addr[IDX_W-1:0]];
      end
      else if (!err_exp)
      begin
         shadow[addr[IDX_W-1:0]] = wdata;
      end
      cmds++;
      if (m == 0)
      begin
         want_read_0  = rd;
         want_err_0   = err_exp;
         want_rdata_0 = rdata_exp;
         cmd_read_0   = rd;
         cmd_addr_0   = addr;
         cmd_wdata_0  = wdata;
         cmd_valid_0  = 1'b1;
      end
      else
      begin
         want_read_1  = rd;
         want_err_1   = err_exp;
         want_rdata_1 = rdata_exp;
         cmd_read_1   = rd;
         cmd_addr_1   = addr;
         cmd_wdata_1  = wdata;
         cmd_valid_1  = 1'b1;
      end
      while (!ready_of(m))
      begin
         @(posedge clk);
         #2;
      end
      @(posedge clk);  // accepted on this edge
      #2;
      if (m == 0)
      begin
         cmd_valid_0 = 1'b0;
      end
      else
      begin
         cmd_valid_1 = 1'b0;
      end
   endtask

   task automatic wait_idle(input int m);
      while (pending_of(m))
      begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic run_cmd(input int m, input logic rd, input logic [`BUS_ADDR_W-1:0] addr,
                          input logic [`BUS_DATA_W-1:0] wdata, input logic stall);
      send_cmd(m, rd, addr, wdata, stall);
      wait_idle(m);
   endtask

   task automatic finish_test(input string name);
      int now_fails;
      now_fails = total_fails();
      tests++;
      $display("test %0d %s: %s", tests, name, (now_fails == seen_fails) ? "ok" : "failed");
      seen_fails = now_fails;
   endtask

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, a transfer never completed", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

   initial
   begin
      void'($urandom(93085));
      arst_n      = 1'b0;
      busy        = 1'b0;
      cmd_valid_0 = 1'b0;
      cmd_valid_1 = 1'b0;
      cmd_read_0  = 1'b0;
      cmd_read_1  = 1'b0;
      cmd_addr_0  = '0;
      cmd_addr_1  = '0;
      cmd_wdata_0 = '0;
      cmd_wdata_1 = '0;
      for (int i = 0; i < `BUS_BANK_WORDS; i++)
      begin
         shadow[i] = '0;
      end
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;

      repeat (5) @(posedge clk);  // quiet ports, no response may show up
      #2;
      run_cmd(0, 1'b1, rand_addr(), '0, 1'b0);
      run_cmd(1, 1'b1, rand_addr(), '0, 1'b0);
      finish_test("reset state and reads of an empty bank");

      for (int i = 0; i < 4; i++)
      begin
         run_cmd(i % 2, 1'b0, `BUS_ADDR_W'(i), $urandom(), 1'b0);
         run_cmd(1 - i % 2, 1'b1, `BUS_ADDR_W'(i), '0, 1'b0);
      end
      finish_test("write then read across masters");

      run_cmd(1, 1'b0, `BUS_ADDR_W'(`BUS_BANK_WORDS), $urandom(), 1'b0);
      run_cmd(0, 1'b1, `BUS_ADDR_W'(`BUS_BANK_WORDS + 3), '0, 1'b0);
      run_cmd(0, 1'b0, '1, $urandom(), 1'b0);
      run_cmd(1, 1'b1, '0, '0, 1'b0);  // low index bits alias word 0 and 15
      run_cmd(1, 1'b1, `BUS_ADDR_W'(`BUS_BANK_WORDS - 1), '0, 1'b0);
      finish_test("out-of-range accesses");

      busy = 1'b1;
      send_cmd(1, 1'b0, `BUS_ADDR_W'(5), $urandom(), 1'b0);
      repeat (8) @(posedge clk);  // a few wait cycles, well below the limit
      #2;
      busy = 1'b0;
      wait_idle(1);
      busy = 1'b1;
      run_cmd(0, 1'b0, `BUS_ADDR_W'(6), $urandom(), 1'b1);
      busy = 1'b0;
      run_cmd(0, 1'b1, `BUS_ADDR_W'(6), '0, 1'b0);
      run_cmd(1, 1'b1, `BUS_ADDR_W'(5), '0, 1'b0);
      finish_test("wait states and timeout");

      fork
         for (int i = 8; i < 12; i++)
         begin
            send_cmd(0, 1'b0, `BUS_ADDR_W'(i), $urandom(), 1'b0);
         end
         for (int i = 0; i < 4; i++)
         begin
            send_cmd(1, 1'b1, `BUS_ADDR_W'(i), '0, 1'b0);
         end
      join
      wait_idle(0);
      wait_idle(1);
      run_cmd(0, 1'b1, `BUS_ADDR_W'(8), '0, 1'b0);  // master 0 granted last
      fork
         run_cmd(0, 1'b1, `BUS_ADDR_W'(9), '0, 1'b0);
         run_cmd(1, 1'b1, `BUS_ADDR_W'(10), '0, 1'b0);
      join
      run_cmd(1, 1'b1, `BUS_ADDR_W'(11), '0, 1'b0);
      finish_test("back-to-back round robin");

      repeat (5) @(posedge clk);
      #2;
      if ((accepts_0 != responses_0) || (accepts_1 != responses_1))
      begin
         $display("CHECK FAILED at %0t: accepted %0d/%0d commands, answered %0d/%0d",
                  $time, accepts_0, accepts_1, responses_0, responses_1);
         end_fails++;
      end
      $display("tests %0d, commands %0d, responses %0d, failures %0d",
               tests, cmds, responses_0 + responses_1, total_fails());
      if (total_fails() == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: list.f
+incdir+hw
hw/bus_pkg.sv
hw/bus_master.sv
hw/bus_arbiter.sv
hw/bus_target.sv
hw/bus_system.sv
test/bus_tb.sv

// File: Makefile
# Verilator build and run of the shared-bus testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = bus_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = All checks passed

SRCS     = $(shell grep -v '^+' $(FILELIST)) hw/bus_defs.svh

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
